/* Makefile */
TOP := tb_pipeline_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* bench/tb_pipeline_top.sv */
// ==================================================
// Testbench for the pipeline top: applies a table of
// instructions with random gaps, checks retirements
// ==================================================
`timescale 1ns/10ps
`default_nettype none

`include "pipeline_defs.svh"

module tb_pipeline_top;

    localparam int RESET_CYCLES   = 16;
    localparam int IDLE_CYCLES    = 20;
    localparam int RETIRE_TIMEOUT = 20;
    localparam int DRAIN_CYCLES   = 20;

    // One stimulus word and what it must retire with
    typedef struct packed {
        logic [`XLEN-1:0]       instr;
        logic                   retires;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   we;
        logic [`XLEN-1:0]       data;
        logic                   rand_gap;
        logic [1:0]             gap;
    } stim_entry_s;

    logic                   clk;
    logic                   rst_n;
    logic                   instr_valid_i;
    logic [`XLEN-1:0]       instr_i;
    logic                   wrb_valid_o;
    logic                   wrb_we_o;
    logic [`REG_ADDR_W-1:0] wrb_rd_o;
    logic [`XLEN-1:0]       wrb_data_o;

    stim_entry_s            stim_q[$];
    integer                 seed;

    pipeline_top pipeline_top_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .wrb_valid_o    (wrb_valid_o),
        .wrb_we_o       (wrb_we_o),
        .wrb_rd_o       (wrb_rd_o),
        .wrb_data_o     (wrb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // RV32I instruction encoders
    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [2:0] f3,
                                               input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
        rtype_word = {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic logic [31:0] itype_word(input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [4:0] rs1, input logic [11:0] imm);
        itype_word = {imm, rs1, f3, rd, `OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
        lui_word = {imm, rd, `OPC_LUI};
    endfunction

    // Negative gap means a random 0 to 3 idle cycles
    task automatic add_entry(input logic [31:0] instr, input logic [4:0] rd, input logic we,
                             input logic [31:0] data, input int gap);
        stim_entry_s e;
        e.instr    = instr;
        e.retires  = 1'b1;
        e.rd       = rd;
        e.we       = we;
        e.data     = data;
        e.rand_gap = (gap < 0);
        e.gap      = gap[1:0];
        stim_q.push_back(e);
    endtask

    task automatic add_dropped(input logic [31:0] instr, input int gap);
        stim_entry_s e;
        e          = '0;
        e.instr    = instr;
        e.rand_gap = (gap < 0);
        e.gap      = gap[1:0];
        stim_q.push_back(e);
    endtask

    task automatic build_table();
        // Constants from LUI and immediates
        add_entry(lui_word(5'd1, 20'h12345), 5'd1, 1'b1, 32'h1234_5000, -1);
        add_entry(itype_word(`F3_ADD_SUB, 5'd1, 5'd1, 12'h678), 5'd1, 1'b1, 32'h1234_5678, 0);
        add_entry(itype_word(`F3_ADD_SUB, 5'd2, 5'd0, 12'hfff), 5'd2, 1'b1, 32'hffff_ffff, -1);
        add_entry(lui_word(5'd4, 20'h80000), 5'd4, 1'b1, 32'h8000_0000, -1);
        add_entry(itype_word(`F3_SRL_SRA, 5'd3, 5'd4, 12'h404), 5'd3, 1'b1, 32'hf800_0000, 0);
        add_entry(itype_word(`F3_XOR, 5'd5, 5'd2, 12'h0f0), 5'd5, 1'b1, 32'hffff_ff0f, -1);
        add_entry(itype_word(`F3_OR, 5'd6, 5'd0, 12'hf00), 5'd6, 1'b1, 32'hffff_ff00, -1);
        add_entry(itype_word(`F3_AND, 5'd7, 5'd5, 12'h7ff), 5'd7, 1'b1, 32'h0000_070f, -1);
        add_entry(itype_word(`F3_SLT, 5'd8, 5'd2, 12'h000), 5'd8, 1'b1, 32'h0000_0001, -1);
        add_entry(itype_word(`F3_SLTU, 5'd9, 5'd2, 12'h001), 5'd9, 1'b1, 32'h0000_0000, -1);
        add_entry(itype_word(`F3_SLTU, 5'd10, 5'd0, 12'hfff), 5'd10, 1'b1, 32'h0000_0001, -1);
        add_entry(itype_word(`F3_SLL, 5'd11, 5'd1, 12'h004), 5'd11, 1'b1, 32'h2345_6780, -1);
        add_entry(itype_word(`F3_SRL_SRA, 5'd12, 5'd4, 12'h01f), 5'd12, 1'b1, 32'h0000_0001, -1);

        // Back to back, operands from the writeback register
        add_entry(itype_word(`F3_ADD_SUB, 5'd13, 5'd0, 12'd100), 5'd13, 1'b1, 32'd100, -1);
        add_entry(rtype_word(`F7_BASE, `F3_ADD_SUB, 5'd14, 5'd13, 5'd13), 5'd14, 1'b1, 32'd200, 0);
        add_entry(rtype_word(`F7_ALT, `F3_ADD_SUB, 5'd15, 5'd14, 5'd1), 5'd15, 1'b1,
                  32'hedcb_aa50, 0);
        add_entry(rtype_word(`F7_BASE, `F3_SLT, 5'd16, 5'd15, 5'd14), 5'd16, 1'b1, 32'd1, 0);
        add_entry(rtype_word(`F7_BASE, `F3_SLTU, 5'd17, 5'd15, 5'd14), 5'd17, 1'b1, 32'd0, -1);
        add_entry(rtype_word(`F7_BASE, `F3_SLT, 5'd18, 5'd4, 5'd2), 5'd18, 1'b1, 32'd1, -1);
        add_entry(rtype_word(`F7_BASE, `F3_SLTU, 5'd19, 5'd2, 5'd4), 5'd19, 1'b1, 32'd0, -1);
        add_entry(itype_word(`F3_ADD_SUB, 5'd20, 5'd0, 12'd7), 5'd20, 1'b1, 32'd7, -1);
        add_entry(rtype_word(`F7_BASE, `F3_SLL, 5'd21, 5'd13, 5'd20), 5'd21, 1'b1,
                  32'h0000_3200, 0);
        add_entry(rtype_word(`F7_BASE, `F3_SRL_SRA, 5'd22, 5'd4, 5'd20), 5'd22, 1'b1,
                  32'h0100_0000, -1);
        add_entry(rtype_word(`F7_ALT, `F3_SRL_SRA, 5'd23, 5'd4, 5'd20), 5'd23, 1'b1,
                  32'hff00_0000, -1);
        // Only the low five bits of 33 shift
        add_entry(itype_word(`F3_ADD_SUB, 5'd24, 5'd0, 12'd33), 5'd24, 1'b1, 32'd33, -1);
        add_entry(rtype_word(`F7_BASE, `F3_SLL, 5'd25, 5'd13, 5'd24), 5'd25, 1'b1, 32'd200, 0);
        add_entry(rtype_word(`F7_BASE, `F3_XOR, 5'd26, 5'd1, 5'd2), 5'd26, 1'b1,
                  32'hedcb_a987, -1);
        add_entry(rtype_word(`F7_BASE, `F3_OR, 5'd27, 5'd13, 5'd20), 5'd27, 1'b1, 32'h67, -1);
        add_entry(rtype_word(`F7_BASE, `F3_AND, 5'd28, 5'd1, 5'd5), 5'd28, 1'b1,
                  32'h1234_5608, -1);

        // Distance two, then with idle cycles between
        add_entry(itype_word(`F3_ADD_SUB, 5'd29, 5'd0, 12'd5), 5'd29, 1'b1, 32'd5, -1);
        add_entry(itype_word(`F3_ADD_SUB, 5'd30, 5'd0, 12'd9), 5'd30, 1'b1, 32'd9, 0);
        add_entry(rtype_word(`F7_BASE, `F3_ADD_SUB, 5'd31, 5'd29, 5'd30), 5'd31, 1'b1, 32'd14, 0);
        add_entry(itype_word(`F3_ADD_SUB, 5'd5, 5'd0, 12'd11), 5'd5, 1'b1, 32'd11, -1);
        add_entry(rtype_word(`F7_BASE, `F3_ADD_SUB, 5'd6, 5'd5, 5'd5), 5'd6, 1'b1, 32'd22, 1);
        add_entry(rtype_word(`F7_BASE, `F3_ADD_SUB, 5'd7, 5'd6, 5'd0), 5'd7, 1'b1, 32'd22, 3);

        // x0 destination, load word and an M extension word
        add_entry(itype_word(`F3_ADD_SUB, 5'd0, 5'd13, 12'd55), 5'd0, 1'b0, 32'd155, -1);
        add_entry(rtype_word(`F7_BASE, `F3_ADD_SUB, 5'd8, 5'd0, 5'd13), 5'd8, 1'b1, 32'd100, 0);
        add_dropped(32'h0000_a483, -1);
        add_entry(itype_word(`F3_ADD_SUB, 5'd9, 5'd9, 12'd1), 5'd9, 1'b1, 32'd1, 0);
        add_dropped(rtype_word(7'b0000001, `F3_ADD_SUB, 5'd10, 5'd1, 5'd2), -1);
        add_entry(rtype_word(`F7_BASE, `F3_ADD_SUB, 5'd10, 5'd10, 5'd0), 5'd10, 1'b1, 32'd1, 0);
        add_entry(`INSTR_NOP, 5'd0, 1'b0, 32'd0, -1);
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic drive_stream();
        int gap;
        foreach (stim_q[i]) begin
            if (stim_q[i].rand_gap) begin
                gap = $unsigned($random(seed)) % 4;
            end else begin
                gap = int'(stim_q[i].gap);
            end
            repeat (gap) begin
                @(negedge clk);
                instr_valid_i = 1'b0;
                instr_i       = '0;
            end
            @(negedge clk);
            instr_valid_i = 1'b1;
            instr_i       = stim_q[i].instr;
        end
        @(negedge clk);
        instr_valid_i = 1'b0;
        instr_i       = '0;
    endtask

    // Sampled at the falling edge, half a cycle after the writeback register loads
    task automatic check_retirements();
        int idx;
        int waited;
        idx = 0;
        while (idx < stim_q.size()) begin
            if (stim_q[idx].retires) begin
                waited = 0;
                @(negedge clk);
                while (!wrb_valid_o) begin
                    waited++;
                    if (waited > RETIRE_TIMEOUT) begin
                        fail_run($sformatf("ERROR: pipeline stopped retiring, entry %0d pending",
                                           idx));
                    end
                    @(negedge clk);
                end
                assert (wrb_rd_o == stim_q[idx].rd)
                    else fail_run($sformatf("mismatch at %0t: entry %0d rd %0d, expected %0d",
                                            $time, idx, wrb_rd_o, stim_q[idx].rd));
                assert (wrb_we_o == stim_q[idx].we)
                    else fail_run($sformatf("mismatch at %0t: entry %0d we %0b, expected %0b",
                                            $time, idx, wrb_we_o, stim_q[idx].we));
                assert (wrb_data_o == stim_q[idx].data)
                    else fail_run($sformatf("mismatch at %0t: entry %0d data %h, expected %h",
                                            $time, idx, wrb_data_o, stim_q[idx].data));
            end
            idx++;
        end
    endtask

    initial begin
        rst_n         = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        seed          = 32'h851a_f78c;
        build_table();

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // Nothing may retire before the first instruction
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            assert (!wrb_valid_o && !wrb_we_o)
                else fail_run("ERROR: writeback active before any instruction was sent");
        end

        fork
            drive_stream();
            check_retirements();
        join

        repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            assert (!wrb_valid_o)
                else fail_run($sformatf("ERROR: extra retirement after the last entry at %0t",
                                        $time));
        end

        $display("Test OK");
        $finish;
    end

endmodule : tb_pipeline_top

`default_nettype wire

/* common/pipeline_defs.svh */
// ==================================================
// Widths, register count and RV32I encodings for
// the integer pipeline, included where needed
// ==================================================
`ifndef PIPELINE_DEFS_SVH
`define PIPELINE_DEFS_SVH

// Datapath and register file geometry
`define XLEN        32
`define REG_COUNT   32
`define REG_ADDR_W  5

// Major opcodes kept in the subset
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111

// funct3 field values
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL_SRA  3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct7 values, alternate selects SUB and SRA
`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000

// ADDI x0, x0, 0
`define INSTR_NOP   32'h0000_0013

`endif

/* common/pipeline_pkg.sv */
// ==================================================
// ALU operation codes and stage payload structs
// shared by all pipeline stages
// ==================================================
`default_nettype none

`include "pipeline_defs.svh"

package pipeline_pkg;

    // ALU functions, pass B carries the LUI immediate
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // Fetch register contents
    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   instr;
    } if2id_s;

    // Decoded instruction with register operands
    typedef struct packed {
        logic                   valid;
        logic                   we;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1_addr;
        logic [`REG_ADDR_W-1:0] rs2_addr;
        logic [`XLEN-1:0]       rs1_data;
        logic [`XLEN-1:0]       rs2_data;
        logic [`XLEN-1:0]       imm;
        logic                   use_imm;
        alu_op_e                alu_op;
    } id2exe_s;

    // Result heading for the register file
    typedef struct packed {
        logic                   valid;
        logic                   we;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       result;
    } exe2wrb_s;

endpackage : pipeline_pkg

`default_nettype wire

/* decode/decode.sv */
// ==================================================
// Instruction decoder for the RV32I ALU subset,
// anything else leaves the stage as a bubble
// ==================================================
`timescale 1ns/10ps
`default_nettype none

`include "pipeline_defs.svh"

module decode
    import pipeline_pkg::*;
(
    input  if2id_s                  if2id_i,

    // Register file read ports
    output logic [`REG_ADDR_W-1:0]  rs1_addr_o,
    output logic [`REG_ADDR_W-1:0]  rs2_addr_o,
    input  logic [`XLEN-1:0]        rs1_data_i,
    input  logic [`XLEN-1:0]        rs2_data_i,

    output id2exe_s                 id2exe_o
);

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       imm_i;
    logic [`XLEN-1:0]       imm_u;
    logic                   legal;
    logic                   use_imm;
    logic [`XLEN-1:0]       imm;
    alu_op_e                alu_op;

    // funct3 to ALU function, alt picks SUB or SRA
    function automatic alu_op_e f3_to_op(input logic [2:0] f3, input logic alt);
        case (f3)
            `F3_ADD_SUB: f3_to_op = alt ? ALU_SUB : ALU_ADD;
            `F3_SLL:     f3_to_op = ALU_SLL;
            `F3_SLT:     f3_to_op = ALU_SLT;
            `F3_SLTU:    f3_to_op = ALU_SLTU;
            `F3_XOR:     f3_to_op = ALU_XOR;
            `F3_SRL_SRA: f3_to_op = alt ? ALU_SRA : ALU_SRL;
            `F3_OR:      f3_to_op = ALU_OR;
            default:     f3_to_op = ALU_AND;
        endcase
    endfunction

    assign opcode     = if2id_i.instr[6:0];
    assign rd         = if2id_i.instr[11:7];
    assign funct3     = if2id_i.instr[14:12];
    assign rs1_addr_o = if2id_i.instr[19:15];
    assign rs2_addr_o = if2id_i.instr[24:20];
    assign funct7     = if2id_i.instr[31:25];

    assign imm_i = {{(`XLEN-12){if2id_i.instr[31]}}, if2id_i.instr[31:20]};
    assign imm_u = {if2id_i.instr[31:12], 12'b0};

    always_comb begin
        legal   = 1'b0;
        use_imm = 1'b0;
        imm     = imm_i;
        alu_op  = ALU_ADD;
        case (opcode)
            `OPC_OP: begin
                // Alternate funct7 only exists for SUB and SRA
                legal  = (funct7 == `F7_BASE) ||
                         ((funct7 == `F7_ALT) &&
                          ((funct3 == `F3_ADD_SUB) || (funct3 == `F3_SRL_SRA)));
                alu_op = f3_to_op(funct3, funct7 == `F7_ALT);
            end
            `OPC_OP_IMM: begin
                use_imm = 1'b1;
                if (funct3 == `F3_SLL) begin
                    legal = (funct7 == `F7_BASE);
                end else if (funct3 == `F3_SRL_SRA) begin
                    legal = (funct7 == `F7_BASE) || (funct7 == `F7_ALT);
                end else begin
                    legal = 1'b1;
                end
                alu_op = f3_to_op(funct3, (funct3 == `F3_SRL_SRA) && (funct7 == `F7_ALT));
            end
            `OPC_LUI: begin
                legal   = 1'b1;
                use_imm = 1'b1;
                imm     = imm_u;
                alu_op  = ALU_PASS_B;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    always_comb begin
        id2exe_o = '0;
        if (if2id_i.valid && legal) begin
            id2exe_o.valid    = 1'b1;
            // x0 destination never writes
            id2exe_o.we       = (rd != '0);
            id2exe_o.rd       = rd;
            id2exe_o.rs1_addr = rs1_addr_o;
            id2exe_o.rs2_addr = rs2_addr_o;
            id2exe_o.rs1_data = rs1_data_i;
            id2exe_o.rs2_data = rs2_data_i;
            id2exe_o.imm      = imm;
            id2exe_o.use_imm  = use_imm;
            id2exe_o.alu_op   = alu_op;
        end
    end

    always_comb begin
        a_legal_op : assert final (!id2exe_o.valid ||
                                   (id2exe_o.alu_op inside {[ALU_ADD:ALU_PASS_B]}))
            else $error("decode: valid instruction with unknown alu_op");
    end

endmodule : decode

`default_nettype wire

/* decode/regfile.sv */
// ==================================================
// Integer register file with two read ports and one
// write port whose data reads see on the same edge
// ==================================================
`timescale 1ns/10ps
`default_nettype none

`include "pipeline_defs.svh"

module regfile
    import pipeline_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`REG_ADDR_W-1:0]  rs1_addr_i,
    input  logic [`REG_ADDR_W-1:0]  rs2_addr_i,
    output logic [`XLEN-1:0]        rs1_data_o,
    output logic [`XLEN-1:0]        rs2_data_o,
    input  exe2wrb_s                wrb_i
);

    logic [`XLEN-1:0]   regs [`REG_COUNT];
    logic               wr_en;

    // Decode clears write enable for an x0 destination
    assign wr_en = wrb_i.valid && wrb_i.we;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wrb_i.rd] <= wrb_i.result;
        end
    end

    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            read_port = '0;
        end else if (wr_en && (wrb_i.rd == addr)) begin
            read_port = wrb_i.result;
        end else begin
            read_port = regs[addr];
        end
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

    a_x0_zero : assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0)
        else $error("regfile: x0 holds a nonzero value");

endmodule : regfile

`default_nettype wire

/* execute/execute.sv */
// ==================================================
// Execute stage: forwards the writeback result into
// the operands and computes the ALU function
// ==================================================
`timescale 1ns/10ps
`default_nettype none

`include "pipeline_defs.svh"

module execute
    import pipeline_pkg::*;
(
    input  id2exe_s     id2exe_i,
    // Writeback register, one instruction ahead
    input  exe2wrb_s    wrb_fwd_i,
    output exe2wrb_s    exe2wrb_o
);

    logic               fwd_hit_rs1;
    logic               fwd_hit_rs2;
    logic [`XLEN-1:0]   op_a;
    logic [`XLEN-1:0]   rs2_val;
    logic [`XLEN-1:0]   op_b;
    logic [4:0]         shamt;
    logic [`XLEN-1:0]   result;

    // Write enable is already clear for x0
    assign fwd_hit_rs1 = wrb_fwd_i.valid && wrb_fwd_i.we &&
                         (wrb_fwd_i.rd == id2exe_i.rs1_addr);
    assign fwd_hit_rs2 = wrb_fwd_i.valid && wrb_fwd_i.we &&
                         (wrb_fwd_i.rd == id2exe_i.rs2_addr);

    assign op_a    = fwd_hit_rs1 ? wrb_fwd_i.result : id2exe_i.rs1_data;
    assign rs2_val = fwd_hit_rs2 ? wrb_fwd_i.result : id2exe_i.rs2_data;
    assign op_b    = id2exe_i.use_imm ? id2exe_i.imm : rs2_val;

    // Shift amount from the low five bits of B
    assign shamt = op_b[4:0];

    always_comb begin
        case (id2exe_i.alu_op)
            ALU_ADD: begin
                result = op_a + op_b;
            end
            ALU_SUB: begin
                result = op_a - op_b;
            end
            ALU_SLL: begin
                result = op_a << shamt;
            end
            ALU_SLT: begin
                result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            end
            ALU_SLTU: begin
                result = {{(`XLEN-1){1'b0}}, op_a < op_b};
            end
            ALU_XOR: begin
                result = op_a ^ op_b;
            end
            ALU_SRL: begin
                result = op_a >> shamt;
            end
            ALU_SRA: begin
                result = $unsigned($signed(op_a) >>> shamt);
            end
            ALU_OR: begin
                result = op_a | op_b;
            end
            ALU_AND: begin
                result = op_a & op_b;
            end
            ALU_PASS_B: begin
                result = op_b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    always_comb begin
        exe2wrb_o.valid  = id2exe_i.valid;
        exe2wrb_o.we     = id2exe_i.we;
        exe2wrb_o.rd     = id2exe_i.rd;
        exe2wrb_o.result = result;
    end

endmodule : execute

`default_nettype wire

/* source/pipe_reg.sv */
// ==================================================
// Stage register for any payload with a valid field,
// loads a zero bubble whenever the input is invalid
// ==================================================
`timescale 1ns/10ps
`default_nettype none

module pipe_reg
    import pipeline_pkg::*;
#(
    parameter type payload_t = if2id_s
) (
    input  logic        clk,
    input  logic        rst_n,
    input  payload_t    d_i,
    output payload_t    q_o
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q_o <= '0;
        end else if (d_i.valid) begin
            q_o <= d_i;
        end else begin
            // Bubble, no stale control survives
            q_o <= '0;
        end
    end

    // Only stages that carry a write enable
    if (type(payload_t) != type(if2id_s)) begin : g_we_chk
        a_bubble_no_write : assert property (
            @(posedge clk) disable iff (!rst_n)
            !q_o.valid |-> !q_o.we
        ) else $error("pipe_reg: bubble carries a register write");
    end

endmodule : pipe_reg

`default_nettype wire

/* source/pipeline_top.sv */
// ==================================================
// In-order RV32I subset pipeline: fetch register,
// decode, execute and writeback with a result port
// ==================================================
`timescale 1ns/10ps
`default_nettype none

`include "pipeline_defs.svh"

module pipeline_top
    import pipeline_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,

    // Instruction stream
    input  logic                    instr_valid_i,
    input  logic [`XLEN-1:0]        instr_i,

    // Retired results
    output logic                    wrb_valid_o,
    output logic                    wrb_we_o,
    output logic [`REG_ADDR_W-1:0]  wrb_rd_o,
    output logic [`XLEN-1:0]        wrb_data_o
);

    if2id_s                 if2id_d;
    if2id_s                 if2id_q;
    id2exe_s                id2exe_d;
    id2exe_s                id2exe_q;
    exe2wrb_s               exe2wrb_d;
    exe2wrb_s               exe2wrb_q;

    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;

    assign if2id_d.valid = instr_valid_i;
    assign if2id_d.instr = instr_i;

    pipe_reg #(.payload_t(if2id_s)) u_if2id (
        .clk        (clk),
        .rst_n      (rst_n),
        .d_i        (if2id_d),
        .q_o        (if2id_q)
    );

    decode u_decode (
        .if2id_i    (if2id_q),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .id2exe_o   (id2exe_d)
    );

    // Written from the writeback register
    regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wrb_i      (exe2wrb_q)
    );

    pipe_reg #(.payload_t(id2exe_s)) u_id2exe (
        .clk        (clk),
        .rst_n      (rst_n),
        .d_i        (id2exe_d),
        .q_o        (id2exe_q)
    );

    execute u_execute (
        .id2exe_i   (id2exe_q),
        .wrb_fwd_i  (exe2wrb_q),
        .exe2wrb_o  (exe2wrb_d)
    );

    pipe_reg #(.payload_t(exe2wrb_s)) u_exe2wrb (
        .clk        (clk),
        .rst_n      (rst_n),
        .d_i        (exe2wrb_d),
        .q_o        (exe2wrb_q)
    );

    assign wrb_valid_o = exe2wrb_q.valid;
    assign wrb_we_o    = exe2wrb_q.we;
    assign wrb_rd_o    = exe2wrb_q.rd;
    assign wrb_data_o  = exe2wrb_q.result;

endmodule : pipeline_top

`default_nettype wire

/* verilog.f */
+incdir+common
common/pipeline_pkg.sv
source/pipe_reg.sv
decode/decode.sv
decode/regfile.sv
execute/execute.sv
source/pipeline_top.sv
bench/tb_pipeline_top.sv
